// ==== sim.f ====
hdl/mrd_pkg.sv
hdl/mrd_div7.sv
hdl/mrd_sink.sv
hdl/mrd_bank_ram.sv
hdl/mrd_source.sv
hdl/mrd_frame_top.sv
tb/tb_mrd_frame_top.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_mrd_frame_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_mrd_frame_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mrd_frame_top;

	import mrd_pkg::*;

	localparam int DEPTH      = 64;
	localparam int NUM_FRAMES = 4;
	localparam int MAX_GAP    = 2; // idle cycles between input beats, at most.
	localparam int JUNK_BEATS = 6;
	localparam int JUNK_FRAME = 2; // the 5x9 frame, long enough to inject into.

	int f1_list [NUM_FRAMES] = '{3, 7, 5, 1};
	int f2_list [NUM_FRAMES] = '{4, 1, 9, 1};

	logic             clk;
	logic             rst_n;
	mrd_st_t          in_st;
	logic [FAC_W-1:0] n1;
	logic [FAC_W-1:0] n2;
	mrd_st_t          out_st;
	logic             source_end;
	logic             busy;
	logic             accept_exp; // beat belongs to a frame the sink must take.

	// reference model state.
	mrd_sample_t frame_mem [0:4095]; // by input sample index.
	int          m_n1         = 1;
	int          m_n2         = 1;
	int          out_cnt      = 0;
	int          frames_taken = 0;
	int          frames_done  = 0;
	int          frame_len;
	int          exp_idx;
	mrd_sample_t exp_data;
	logic        exp_sop;
	logic        exp_eop;
	logic        eop_acc;

	mrd_frame_top #(
		.DEPTH (DEPTH)
	) DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_st      (in_st),
		.n1         (n1),
		.n2         (n2),
		.out_st     (out_st),
		.source_end (source_end),
		.busy       (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign eop_acc = in_st.valid && in_st.eop && accept_exp;

	// output j = q*n1 + r carries input sample r*n2 + q.
	always_comb
	begin
		frame_len = m_n1 * m_n2;
		exp_idx   = (out_cnt % m_n1) * m_n2 + out_cnt / m_n1;
		exp_data  = frame_mem[exp_idx];
		exp_sop   = (out_cnt == 0);
		exp_eop   = (out_cnt == frame_len - 1);
	end

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			m_n1         <= 1;
			m_n2         <= 1;
			out_cnt      <= 0;
			frames_taken <= 0;
			frames_done  <= 0;
		end
		else
		begin
			if (eop_acc)
			begin
				m_n1         <= int'(n1); // factors of the frame just stored.
				m_n2         <= int'(n2);
				out_cnt      <= 0;
				frames_taken <= frames_taken + 1;
			end
			else if (out_st.valid)
				out_cnt <= out_cnt + 1;
			if (source_end)
				frames_done <= frames_done + 1;
		end
	end

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		$display("Simulation FAILED");
		$fatal(1, "wrong value on %s", name);
	endtask

	task automatic check_failed(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "check failed");
	endtask

	a_data : assert property (@(posedge clk) disable iff (!rst_n)
		out_st.valid |-> (out_st.data == exp_data))
		else value_mismatch("out_st.data", 32'($sampled(out_st.data)), 32'($sampled(exp_data)));

	a_sop : assert property (@(posedge clk) disable iff (!rst_n)
		out_st.valid |-> (out_st.sop == exp_sop))
		else value_mismatch("out_st.sop", 32'($sampled(out_st.sop)), 32'($sampled(exp_sop)));

	a_eop : assert property (@(posedge clk) disable iff (!rst_n)
		out_st.valid |-> (out_st.eop == exp_eop))
		else value_mismatch("out_st.eop", 32'($sampled(out_st.eop)), 32'($sampled(exp_eop)));

	a_len : assert property (@(posedge clk) disable iff (!rst_n)
		out_st.valid |-> (out_cnt < frame_len))
		else check_failed("more output beats than the frame holds");

	// beats of one frame come back to back.
	a_contig : assert property (@(posedge clk) disable iff (!rst_n)
		(out_st.valid && !out_st.eop) |=> out_st.valid)
		else check_failed("gap in the output stream before eop");

	a_strobe_idle : assert property (@(posedge clk) disable iff (!rst_n)
		!out_st.valid |-> !(out_st.sop || out_st.eop))
		else check_failed("sop or eop raised without valid");

	// write, frame_done, read, ram, output register.
	a_first : assert property (@(posedge clk) disable iff (!rst_n)
		$past(eop_acc, 5) |-> (out_st.valid && out_st.sop && !$past(out_st.valid)))
		else check_failed("first output beat not at the expected cycle after the input eop");

	a_end : assert property (@(posedge clk) disable iff (!rst_n)
		source_end == $past(out_st.valid && out_st.eop))
		else check_failed("source_end did not pulse exactly once, one cycle after eop");

	a_busy_rise : assert property (@(posedge clk) disable iff (!rst_n)
		$past(eop_acc, 3) |-> (busy && !$past(busy)))
		else check_failed("busy did not rise one cycle after frame_done");

	a_busy_fall : assert property (@(posedge clk) disable iff (!rst_n)
		$past(source_end) |-> !busy)
		else check_failed("busy still high one cycle after source_end");

	a_idle : assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !(out_st.valid || source_end))
		else check_failed("output activity while busy is low");

	a_reset_idle : assert property (@(posedge clk) disable iff (!rst_n)
		(frames_taken == 0) |-> !busy)
		else check_failed("busy high before any frame was sent");

	task automatic send_frame(input int f1, input int f2);
		int          len;
		int          gap;
		mrd_sample_t sample;
		len = f1 * f2;
		@(posedge clk);
		#2;
		n1 = FAC_W'(f1);
		n2 = FAC_W'(f2);
		for (int i = 0; i < len; i++)
		begin
			gap = int'($urandom % (MAX_GAP + 1));
			repeat (gap)
			begin
				in_st      = '0;
				accept_exp = 1'b0;
				@(posedge clk);
				#2;
			end
			sample.re    = 16'($urandom);
			sample.im    = 16'($urandom);
			frame_mem[i] = sample;
			in_st        = '{valid: 1'b1, sop: (i == 0), eop: (i == len - 1), data: sample};
			accept_exp   = 1'b1;
			@(posedge clk);
			#2;
		end
		in_st      = '0;
		accept_exp = 1'b0;
	endtask

	// a whole fake frame while the buffer is being read out.
	task automatic send_junk();
		mrd_sample_t junk;
		@(posedge clk);
		while (!busy)
			@(posedge clk);
		#2;
		for (int i = 0; i < JUNK_BEATS; i++)
		begin
			junk.re = 16'($urandom);
			junk.im = 16'($urandom);
			in_st   = '{valid: 1'b1, sop: (i == 0), eop: (i == JUNK_BEATS - 1), data: junk};
			@(posedge clk);
			#2;
		end
		in_st = '0;
	endtask

	task automatic wait_frame_end();
		do
			@(posedge clk);
		while (!source_end);
		do
			@(posedge clk);
		while (busy);
	endtask

	function automatic int cycle_budget();
		int total;
		total = 32; // reset and the idle window.
		for (int f = 0; f < NUM_FRAMES; f++)
			total += f1_list[f] * f2_list[f] * (2 + MAX_GAP) + 20;
		return total;
	endfunction

	initial
	begin
		int limit;
		limit = cycle_budget();
		repeat (limit) @(posedge clk);
		$display("timeout, the frames did not finish within %0d cycles", limit);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		void'($urandom(1));
		rst_n      = 1'b0;
		in_st      = '0;
		n1         = FAC_W'(1);
		n2         = FAC_W'(1);
		accept_exp = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (8) @(posedge clk); // nothing may come out yet.
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			send_frame(f1_list[f], f2_list[f]);
			if (f == JUNK_FRAME)
				send_junk();
			wait_frame_end();
		end
		repeat (4) @(posedge clk);
		if (frames_done == NUM_FRAMES)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
			value_mismatch("frames_done", 32'(frames_done), 32'(NUM_FRAMES));
	end

endmodule

`default_nettype wire

// ==== hdl/mrd_frame_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mrd_frame_top #(
	parameter int DEPTH = 64
) (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire mrd_pkg::mrd_st_t          in_st,
	input  wire logic [mrd_pkg::FAC_W-1:0] n1,
	input  wire logic [mrd_pkg::FAC_W-1:0] n2,
	output mrd_pkg::mrd_st_t               out_st,
	output logic                           source_end,
	output logic                           busy
);

	import mrd_pkg::*;

	mrd_wr_t     wr;
	mrd_rd_t     rd;
	mrd_sample_t rd_data;
	logic        frame_done;

	mrd_sink u_sink (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_st      (in_st),
		.busy       (busy),
		.wr         (wr),
		.frame_done (frame_done)
	);

	mrd_bank_ram #(
		.DEPTH (DEPTH)
	) u_bank_ram (
		.clk     (clk),
		.wr      (wr),
		.rd      (rd),
		.rd_data (rd_data)
	);

	mrd_source u_source (
		.clk        (clk),
		.rst_n      (rst_n),
		.n1         (n1),
		.n2         (n2),
		.frame_done (frame_done),
		.rd         (rd),
		.rd_data    (rd_data),
		.out_st     (out_st),
		.source_end (source_end)
	);

	// high from the full frame until it has been read out.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (frame_done)
			busy <= 1'b1;
		else if (source_end)
			busy <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hdl/mrd_source.sv ====
`timescale 1ns/1ns
`default_nettype none

module mrd_source (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic [mrd_pkg::FAC_W-1:0] n1,
	input  wire logic [mrd_pkg::FAC_W-1:0] n2,
	input  wire logic                      frame_done,
	output mrd_pkg::mrd_rd_t               rd,
	input  wire mrd_pkg::mrd_sample_t      rd_data,
	output mrd_pkg::mrd_st_t               out_st,
	output logic                           source_end
);

	import mrd_pkg::*;

	logic             active;
	logic [FAC_W-1:0] r;   // inner count, up to n1-1.
	logic [FAC_W-1:0] q;   // outer count, up to n2-1.
	logic [IDX_W-1:0] idx; // r*n2 + q.
	logic [IDX_W-1:0] word;
	logic [2:0]       bank;
	logic             r_wrap;
	logic             q_wrap;
	logic             first;
	logic             last;

	logic             valid_d1;
	logic             sop_d1;
	logic             eop_d1;
	logic             out_valid;
	logic             out_sop;
	logic             out_eop;
	mrd_sample_t      out_data;

	assign r_wrap = (r == n1 - 1'b1);
	assign q_wrap = (q == n2 - 1'b1);
	assign first  = active && (r == '0) && (q == '0);
	assign last   = active && r_wrap && q_wrap;

	// position j = q*n1 + r reads input sample r*n2 + q.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			r      <= '0;
			q      <= '0;
			idx    <= '0;
		end
		else if (frame_done)
		begin
			active <= 1'b1;
			r      <= '0;
			q      <= '0;
			idx    <= '0;
		end
		else if (active)
		begin
			if (r_wrap)
			begin
				r   <= '0;
				q   <= q + 1'b1;
				idx <= IDX_W'(q) + 1'b1; // rewind to the next column.
				if (q_wrap)
					active <= 1'b0;
			end
			else
			begin
				r   <= r + 1'b1;
				idx <= idx + IDX_W'(n2);
			end
		end
	end

	mrd_div7 u_div7 (
		.dividend  (idx),
		.quotient  (word),
		.remainder (bank)
	);

	assign rd = '{rden: active ? bank_sel(bank) : '0, addr: word};

	// two stages, ram latency plus the output register.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_d1   <= 1'b0;
			sop_d1     <= 1'b0;
			eop_d1     <= 1'b0;
			out_valid  <= 1'b0;
			out_sop    <= 1'b0;
			out_eop    <= 1'b0;
			source_end <= 1'b0;
		end
		else
		begin
			valid_d1   <= active;
			sop_d1     <= first;
			eop_d1     <= last;
			out_valid  <= valid_d1;
			out_sop    <= sop_d1;
			out_eop    <= eop_d1;
			source_end <= out_eop; // the cycle after the last beat.
		end
	end

	always_ff @(posedge clk)
	begin
		if (valid_d1)
			out_data <= rd_data;
	end

	assign out_st = '{valid: out_valid, sop: out_sop, eop: out_eop, data: out_data};

	// sink has to wait for busy to drop.
	a_no_overlap : assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> !(active || valid_d1 || out_valid))
		else $error("frame_done during read-out");

endmodule

`default_nettype wire

// ==== hdl/mrd_bank_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module mrd_bank_ram #(
	parameter int DEPTH = 64
) (
	input  wire logic             clk,
	input  wire mrd_pkg::mrd_wr_t wr,
	input  wire mrd_pkg::mrd_rd_t rd,
	output mrd_pkg::mrd_sample_t  rd_data
);

	import mrd_pkg::*;

	localparam int AW = $clog2(DEPTH);

	mrd_sample_t mem [NUM_BANKS][DEPTH];

	// write port, wren picks the bank.
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			if (wr.wren[NUM_BANKS-1-b])
				mem[b][wr.addr[AW-1:0]] <= wr.data;
		end
	end

	// registered read, one cycle latency.
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			if (rd.rden[NUM_BANKS-1-b])
				rd_data <= mem[b][rd.addr[AW-1:0]];
		end
	end

	a_sel_onehot : assert property (@(posedge clk)
		$onehot0(wr.wren) && $onehot0(rd.rden))
		else $error("bank select not one-hot");

	// frame longer than the banks can hold.
	a_addr_range : assert property (@(posedge clk)
		((wr.wren != '0) |-> (int'(wr.addr) < DEPTH)) and
		((rd.rden != '0) |-> (int'(rd.addr) < DEPTH)))
		else $error("bank address out of range");

endmodule

`default_nettype wire

// ==== hdl/mrd_sink.sv ====
`timescale 1ns/1ns
`default_nettype none

module mrd_sink (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire mrd_pkg::mrd_st_t in_st,
	input  wire logic             busy,
	output mrd_pkg::mrd_wr_t      wr,
	output logic                  frame_done
);

	import mrd_pkg::*;

	logic                 accept;
	logic                 lock;
	logic                 eop_q;
	logic [IDX_W-1:0]     idx;
	logic [IDX_W-1:0]     idx_cur;
	logic [IDX_W-1:0]     word;
	logic [2:0]           bank;
	logic [NUM_BANKS-1:0] wren_q;
	logic [IDX_W-1:0]     addr_q;
	mrd_sample_t          data_q;

	// closes the gap between the eop beat and busy going high.
	assign accept = in_st.valid && !busy && !lock;

	assign idx_cur = in_st.sop ? '0 : idx; // sop restarts the frame.

	mrd_div7 u_div7 (
		.dividend  (idx_cur),
		.quotient  (word),
		.remainder (bank)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			idx        <= '0;
			lock       <= 1'b0;
			wren_q     <= '0;
			eop_q      <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			wren_q     <= accept ? bank_sel(bank) : '0;
			eop_q      <= accept && in_st.eop;
			frame_done <= eop_q; // one cycle after the eop write.
			if (accept)
				idx <= idx_cur + 1'b1;
			if (accept && in_st.eop)
				lock <= 1'b1;
			else if (busy)
				lock <= 1'b0; // busy holds off beats from here on.
		end
	end

	// payload follows the write strobe.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			addr_q <= word;
			data_q <= in_st.data;
		end
	end

	assign wr = '{wren: wren_q, addr: addr_q, data: data_q};

	// the frame in the banks must not change during read-out.
	a_no_wr_busy : assert property (@(posedge clk) disable iff (!rst_n)
		(wr.wren != '0) |-> !busy)
		else $error("bank write while busy");

endmodule

`default_nettype wire

// ==== hdl/mrd_div7.sv ====
`timescale 1ns/1ns
`default_nettype none

module mrd_div7 (
	input  wire logic [mrd_pkg::IDX_W-1:0] dividend,
	output logic [mrd_pkg::IDX_W-1:0]      quotient,
	output logic [2:0]                     remainder
);

	import mrd_pkg::*;

	// floor(2^16 / 7), so the estimate never overshoots.
	localparam logic [15:0]      RECIP = 16'((1 << 16) / NUM_BANKS);
	localparam logic [IDX_W-1:0] BANKS = IDX_W'(NUM_BANKS);

	logic [IDX_W+15:0] prod;
	logic [IDX_W-1:0]  q_est;
	logic [IDX_W-1:0]  back;
	logic [IDX_W-1:0]  rem_est;
	logic [IDX_W-1:0]  rem_fix;
	logic              fix;

	assign prod  = dividend * RECIP;
	assign q_est = prod[IDX_W+15:16]; // at most one below the true quotient.

	assign back    = q_est * BANKS;
	assign rem_est = dividend - back;

	// one correction step is enough for a 12 bit dividend.
	assign fix     = (rem_est >= BANKS);
	assign rem_fix = rem_est - BANKS;

	assign quotient  = q_est + IDX_W'(fix);
	assign remainder = fix ? rem_fix[2:0] : rem_est[2:0];

endmodule

`default_nettype wire

// ==== hdl/mrd_pkg.sv ====
`default_nettype none

package mrd_pkg;

	localparam int DATA_W    = 16; // one real or imaginary part.
	localparam int IDX_W     = 12; // sample index within a frame.
	localparam int FAC_W     = 6;  // one length factor, 1 to 63.
	localparam int NUM_BANKS = 7;

	typedef struct packed {
		logic [DATA_W-1:0] re;
		logic [DATA_W-1:0] im;
	} mrd_sample_t;

	// one stream beat, used on both the input and output side.
	typedef struct packed {
		logic        valid;
		logic        sop;
		logic        eop;
		mrd_sample_t data;
	} mrd_st_t;

	typedef struct packed {
		logic [NUM_BANKS-1:0] wren; // one-hot, bank 0 is the msb.
		logic [IDX_W-1:0]     addr;
		mrd_sample_t          data;
	} mrd_wr_t;

	typedef struct packed {
		logic [NUM_BANKS-1:0] rden; // same bank order as wren.
		logic [IDX_W-1:0]     addr;
	} mrd_rd_t;

	// bank number to one-hot select, out of range gives no bank.
	function automatic logic [NUM_BANKS-1:0] bank_sel(input logic [2:0] bank);
		logic [NUM_BANKS-1:0] sel;
		sel = '0;
		if (int'(bank) < NUM_BANKS)
			sel[NUM_BANKS-1-int'(bank)] = 1'b1;
		return sel;
	endfunction

endpackage

`default_nettype wire
